/* logic/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// operand and result width
`define EX_DATA_W 32

// register specifier width
`define EX_DR_W 3

// rep iteration counter width, loaded from ecx
`define EX_REP_W 32

`endif

/* logic/ex_uop_pkg.sv */
package ex_uop_pkg;

  // cmp computes like sub but loads no register
  typedef enum logic [2:0] {
    aluk_add    = 3'd0,
    aluk_sub    = 3'd1,
    aluk_and    = 3'd2,
    aluk_or     = 3'd3,
    aluk_xor    = 3'd4,
    aluk_not    = 3'd5,
    aluk_pass_b = 3'd6,
    aluk_cmp    = 3'd7
  } aluk_e;

  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_word  = 2'd1,
    size_dword = 2'd2
  } size_e;

  typedef enum logic {
    fu_alu   = 1'b0,
    fu_shift = 1'b1
  } fu_e;

  typedef struct packed {
    aluk_e aluk;
    size_e size;
    fu_e   fu;
    logic  shift_dir;
    logic  pass_a;
    logic  is_xchg;
    logic  is_cmpxchg;
    logic  is_cmps_first;
    logic  is_cmps_second;
    logic  is_rep;
    logic  ld_gpr1;
    logic  ld_gpr2;
    logic  dcache_write;
  } uop_t;

endpackage

/* logic/ex_flags_pkg.sv */
package ex_flags_pkg;

  // x86 eflags positions, unused bits read as zero
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        of;
    logic [2:0]  rsvd_10_8;
    logic        sf;
    logic        zf;
    logic        rsvd_5;
    logic        af;
    logic        rsvd_3;
    logic        pf;
    logic        rsvd_1;
    logic        cf;
  } eflags_bits_t;

  typedef union packed {
    logic [31:0]  word;
    eflags_bits_t bits;
  } eflags_u;

endpackage

/* logic/ex_ifs.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

interface ex_operand_if;
  import ex_uop_pkg::*;

  logic [`EX_DATA_W-1:0] a;
  logic [`EX_DATA_W-1:0] b;
  aluk_e                 aluk;
  size_e                 size;
  logic                  shift_dir;

  // cmps sequencer picks b and captures a
  modport source (input a, output b);
  modport consumer (input a, b, aluk, size, shift_dir);
endinterface

interface ex_fu_if;
  import ex_flags_pkg::*;

  logic [`EX_DATA_W-1:0] alu_result;
  eflags_u               alu_flags;
  logic [`EX_DATA_W-1:0] shift_result;
  eflags_u               shift_flags;

  modport alu_source (output alu_result, alu_flags);
  modport shift_source (output shift_result, shift_flags);
  modport sink (input alu_result, alu_flags, shift_result, shift_flags);
endinterface

/* logic/cmps_seq_ex.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module cmps_seq_ex (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_v,
  input  logic                  wb_stall,
  input  ex_uop_pkg::uop_t      ex_uop,
  input  logic [`EX_DATA_W-1:0] ex_b,
  input  logic                  zf,
  ex_operand_if.source          opnd,
  input  logic                  count_is_one,
  output logic                  rep_load,
  output logic                  rep_dec,
  output logic                  rep_again
);

  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_first_held = 2'd1,
    st_rep_wait   = 2'd2
  } state_e;

  state_e                state;
  state_e                state_next;
  logic                  accept;
  logic [`EX_DATA_W-1:0] held;

  assign accept = ex_v & ~wb_stall;

  // second uop compares against the captured first operand
  assign opnd.b = ex_uop.is_cmps_second ? held : ex_b;

  // counter is loaded only on the first pass of a rep sequence
  assign rep_load = accept & ex_uop.is_cmps_first & ex_uop.is_rep & (state != st_rep_wait);
  assign rep_dec  = accept & ex_uop.is_cmps_second & ex_uop.is_rep;
  assign rep_again = ex_v & ex_uop.is_cmps_second & ex_uop.is_rep & zf & ~count_is_one;

  always_comb begin
    state_next = state;
    if (accept && ex_uop.is_cmps_first) begin
      state_next = st_first_held;
    end else if (accept && ex_uop.is_cmps_second) begin
      state_next = rep_again ? st_rep_wait : st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      held  <= '0;
    end else begin
      state <= state_next;
      if (accept && ex_uop.is_cmps_first) begin
        held <= opnd.a;
      end
    end
  end

endmodule

/* logic/rep_count_ex.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module rep_count_ex (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic                 dec,
  input  logic [`EX_REP_W-1:0] load_value,
  output logic                 count_is_one
);

  logic [`EX_REP_W-1:0] count;

  // load_value assumed nonzero
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  assign count_is_one = (count == `EX_REP_W'(1));

endmodule

/* logic/alu32.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module alu32 (
  ex_operand_if.consumer opnd,
  ex_fu_if.alu_source    fu
);
  import ex_uop_pkg::*;
  import ex_flags_pkg::*;

  logic                  is_sub;
  logic                  arith;
  logic [`EX_DATA_W-1:0] b_eff;
  logic [`EX_DATA_W:0]   sum;
  logic [`EX_DATA_W:0]   carry;
  logic [`EX_DATA_W-1:0] raw;
  logic [`EX_DATA_W-1:0] res;
  logic                  c_top;
  logic                  c_msb;
  logic                  zero;
  logic                  sign;
  eflags_u               flags;

  assign is_sub = (opnd.aluk == aluk_sub) || (opnd.aluk == aluk_cmp);
  assign b_eff  = is_sub ? ~opnd.b : opnd.b;
  assign sum    = {1'b0, opnd.a} + {1'b0, b_eff} + {{`EX_DATA_W{1'b0}}, is_sub};
  // carry into each bit position
  assign carry  = {1'b0, opnd.a} ^ {1'b0, b_eff} ^ sum;

  always_comb begin
    raw   = sum[`EX_DATA_W-1:0];
    arith = 1'b0;
    case (opnd.aluk)
      aluk_add, aluk_sub, aluk_cmp: arith = 1'b1;
      aluk_and:    raw = opnd.a & opnd.b;
      aluk_or:     raw = opnd.a | opnd.b;
      aluk_xor:    raw = opnd.a ^ opnd.b;
      aluk_not:    raw = ~opnd.a;
      aluk_pass_b: raw = opnd.b;
      default:     arith = 1'b1;
    endcase
  end

  // upper bits outside the data size keep a
  always_comb begin
    case (opnd.size)
      size_byte: begin
        res   = {opnd.a[`EX_DATA_W-1:8], raw[7:0]};
        c_top = carry[8];
        c_msb = carry[7];
        zero  = (raw[7:0] == 8'h00);
        sign  = raw[7];
      end
      size_word: begin
        res   = {opnd.a[`EX_DATA_W-1:16], raw[15:0]};
        c_top = carry[16];
        c_msb = carry[15];
        zero  = (raw[15:0] == 16'h0000);
        sign  = raw[15];
      end
      default: begin
        res   = raw;
        c_top = carry[`EX_DATA_W];
        c_msb = carry[`EX_DATA_W-1];
        zero  = (raw == '0);
        sign  = raw[`EX_DATA_W-1];
      end
    endcase
  end

  always_comb begin
    flags.word = '0;
    // carry inverted on subtract so cf/af read as borrow
    flags.bits.cf = arith & (c_top ^ is_sub);
    flags.bits.af = arith & (carry[4] ^ is_sub);
    flags.bits.of = arith & (c_top ^ c_msb);
    flags.bits.zf = zero;
    flags.bits.sf = sign;
    flags.bits.pf = ~^res[7:0];
  end

  assign fu.alu_result = res;
  assign fu.alu_flags  = flags;

endmodule

/* logic/shifter32.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module shifter32 (
  ex_operand_if.consumer opnd,
  ex_fu_if.shift_source  fu
);
  import ex_flags_pkg::*;

  logic [4:0]            count;
  logic [`EX_DATA_W:0]   right_ext;
  logic [`EX_DATA_W:0]   left_ext;
  logic [`EX_DATA_W-1:0] res;
  logic                  last_out;
  eflags_u               flags;

  assign count = opnd.b[4:0];

  // one spare bit catches the last bit shifted out
  assign right_ext = {opnd.a, 1'b0} >> count;
  assign left_ext  = {1'b0, opnd.a} << count;

  assign res      = opnd.shift_dir ? right_ext[`EX_DATA_W:1] : left_ext[`EX_DATA_W-1:0];
  assign last_out = opnd.shift_dir ? right_ext[0] : left_ext[`EX_DATA_W];

  always_comb begin
    flags.word = '0;
    if (count != 5'd0) begin
      flags.bits.cf = last_out;
      flags.bits.zf = (res == '0);
      flags.bits.sf = res[`EX_DATA_W-1];
      flags.bits.pf = ~^res[7:0];
    end
  end

  assign fu.shift_result = res;
  assign fu.shift_flags  = flags;

endmodule

/* logic/result_select_ex.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module result_select_ex (
  input  logic                  ex_v,
  input  ex_uop_pkg::uop_t      ex_uop,
  input  logic [`EX_DATA_W-1:0] ex_a,
  input  logic [`EX_DATA_W-1:0] ex_b,
  input  logic [`EX_DATA_W-1:0] ex_c,
  ex_fu_if.sink                 fu,
  output logic [`EX_DATA_W-1:0] result_a,
  output logic [`EX_DATA_W-1:0] result_b,
  output ex_flags_pkg::eflags_u flags,
  output logic                  zf,
  output logic                  ld_gpr1,
  output logic                  ld_gpr2,
  output logic                  dcache_write,
  output logic                  dep_v_ld_gpr1,
  output logic                  dep_v_ld_gpr2,
  output logic                  dep_v_dcache_write
);
  import ex_uop_pkg::*;

  logic sel_shift;

  assign sel_shift = (ex_uop.fu == fu_shift);
  assign flags     = sel_shift ? fu.shift_flags : fu.alu_flags;
  assign zf        = flags.bits.zf;

  always_comb begin
    result_a     = sel_shift ? fu.shift_result : fu.alu_result;
    result_b     = ex_b;
    ld_gpr1      = ex_uop.ld_gpr1;
    ld_gpr2      = ex_uop.ld_gpr2;
    dcache_write = ex_uop.dcache_write;
    if (ex_uop.pass_a) begin
      result_a = ex_a;
    end
    if (ex_uop.is_xchg) begin
      result_a = ex_b;
      result_b = ex_a;
    end
    if (ex_uop.is_cmpxchg) begin
      if (zf) begin
        // equal: source goes to destination
        result_a = ex_c;
        ld_gpr2  = 1'b0;
      end else begin
        // not equal: accumulator takes destination
        result_a     = ex_b;
        ld_gpr1      = 1'b1;
        dcache_write = 1'b0;
      end
    end
    if (ex_uop.aluk == aluk_cmp) begin
      ld_gpr1 = 1'b0;
    end
  end

  assign dep_v_ld_gpr1      = ld_gpr1 & ex_v;
  assign dep_v_ld_gpr2      = ld_gpr2 & ex_v;
  assign dep_v_dcache_write = dcache_write & ex_v;

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module execute (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_v,
  input  ex_uop_pkg::uop_t      ex_uop,
  input  logic [`EX_DATA_W-1:0] ex_a,
  input  logic [`EX_DATA_W-1:0] ex_b,
  input  logic [`EX_DATA_W-1:0] ex_c,
  input  logic [`EX_DR_W-1:0]   ex_dr1,
  input  logic [`EX_DR_W-1:0]   ex_dr2,
  input  logic                  wb_stall,
  output logic                  wb_v_next,
  output logic [`EX_DATA_W-1:0] wb_result_a_next,
  output logic [`EX_DATA_W-1:0] wb_result_b_next,
  output ex_flags_pkg::eflags_u wb_flags_next,
  output logic                  wb_ld_gpr1_next,
  output logic                  wb_ld_gpr2_next,
  output logic                  wb_dcache_write_next,
  output logic [`EX_DR_W-1:0]   wb_dr1_next,
  output logic [`EX_DR_W-1:0]   wb_dr2_next,
  output logic                  dep_v_ld_gpr1,
  output logic                  dep_v_ld_gpr2,
  output logic                  dep_v_dcache_write,
  output logic                  rep_again
);

  ex_operand_if opnd ();
  ex_fu_if      fu ();

  logic zf;
  logic count_is_one;
  logic rep_load;
  logic rep_dec;

  assign opnd.a         = ex_a;
  assign opnd.aluk      = ex_uop.aluk;
  assign opnd.size      = ex_uop.size;
  assign opnd.shift_dir = ex_uop.shift_dir;

  // valid and specifiers go straight to the wb latches
  assign wb_v_next   = ex_v;
  assign wb_dr1_next = ex_dr1;
  assign wb_dr2_next = ex_dr2;

  cmps_seq_ex u_cmps_seq_ex (
    .clk          (clk),
    .rst          (rst),
    .ex_v         (ex_v),
    .wb_stall     (wb_stall),
    .ex_uop       (ex_uop),
    .ex_b         (ex_b),
    .zf           (zf),
    .opnd         (opnd.source),
    .count_is_one (count_is_one),
    .rep_load     (rep_load),
    .rep_dec      (rep_dec),
    .rep_again    (rep_again)
  );

  // ecx seeds the repe counter
  rep_count_ex u_rep_count_ex (
    .clk          (clk),
    .rst          (rst),
    .load         (rep_load),
    .dec          (rep_dec),
    .load_value   (ex_c),
    .count_is_one (count_is_one)
  );

  alu32 u_alu32 (
    .opnd (opnd.consumer),
    .fu   (fu.alu_source)
  );

  shifter32 u_shifter32 (
    .opnd (opnd.consumer),
    .fu   (fu.shift_source)
  );

  result_select_ex u_result_select_ex (
    .ex_v               (ex_v),
    .ex_uop             (ex_uop),
    .ex_a               (ex_a),
    .ex_b               (ex_b),
    .ex_c               (ex_c),
    .fu                 (fu.sink),
    .result_a           (wb_result_a_next),
    .result_b           (wb_result_b_next),
    .flags              (wb_flags_next),
    .zf                 (zf),
    .ld_gpr1            (wb_ld_gpr1_next),
    .ld_gpr2            (wb_ld_gpr2_next),
    .dcache_write       (wb_dcache_write_next),
    .dep_v_ld_gpr1      (dep_v_ld_gpr1),
    .dep_v_ld_gpr2      (dep_v_ld_gpr2),
    .dep_v_dcache_write (dep_v_dcache_write)
  );

endmodule

/* sim/execute_checker.sv */
`timescale 1ns/1ps

module execute_checker (
  input logic clk,
  input logic rst,
  input logic ex_v,
  input logic rep_again,
  input logic dep_v_ld_gpr1,
  input logic dep_v_ld_gpr2,
  input logic dep_v_dcache_write
);

  // repeat request belongs to a live second uop
  rep_again_valid: assert property (
    @(posedge clk) disable iff (rst) rep_again |-> ex_v
  ) else $error("rep_again high while ex_v is low");

  dep_v_valid: assert property (
    @(posedge clk) disable iff (rst)
      (dep_v_ld_gpr1 || dep_v_ld_gpr2 || dep_v_dcache_write) |-> ex_v
  ) else $error("dependency valid high while ex_v is low");

  // sequencer leaves reset idle
  rep_quiet_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> !rep_again
  ) else $error("rep_again high in the first cycle after reset");

endmodule

bind execute execute_checker i_checker (
  .clk                (clk),
  .rst                (rst),
  .ex_v               (ex_v),
  .rep_again          (rep_again),
  .dep_v_ld_gpr1      (dep_v_ld_gpr1),
  .dep_v_ld_gpr2      (dep_v_ld_gpr2),
  .dep_v_dcache_write (dep_v_dcache_write)
);

/* sim/execute_tb.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module execute_tb;
  import ex_uop_pkg::*;
  import ex_flags_pkg::*;

  localparam int n_alu   = 80;
  localparam int n_shift = 40;
  localparam int n_cmpx  = 30;
  localparam int n_cmps  = 12;
  // reset, one cycle per op, idle cycles between tests
  localparam int test_cycles = 3 + n_alu + n_shift + n_cmpx + 4 * n_cmps + 20;
  localparam int cycle_limit = test_cycles + 100;

  typedef struct packed {
    logic [31:0] result_a;
    logic [31:0] result_b;
    eflags_u     flags;
    logic        ld_gpr1;
    logic        ld_gpr2;
    logic        dcache_write;
    logic        rep_again;
  } expect_t;

  logic                  clk;
  logic                  rst;
  logic                  ex_v;
  uop_t                  ex_uop;
  logic [`EX_DATA_W-1:0] ex_a;
  logic [`EX_DATA_W-1:0] ex_b;
  logic [`EX_DATA_W-1:0] ex_c;
  logic [`EX_DR_W-1:0]   ex_dr1;
  logic [`EX_DR_W-1:0]   ex_dr2;
  logic                  wb_stall;
  logic                  wb_v_next;
  logic [`EX_DATA_W-1:0] wb_result_a_next;
  logic [`EX_DATA_W-1:0] wb_result_b_next;
  eflags_u               wb_flags_next;
  logic                  wb_ld_gpr1_next;
  logic                  wb_ld_gpr2_next;
  logic                  wb_dcache_write_next;
  logic [`EX_DR_W-1:0]   wb_dr1_next;
  logic [`EX_DR_W-1:0]   wb_dr2_next;
  logic                  dep_v_ld_gpr1;
  logic                  dep_v_ld_gpr2;
  logic                  dep_v_dcache_write;
  logic                  rep_again;

  // model of the held cmps operand and the rep counter
  logic [31:0] m_held;
  logic [31:0] m_count;
  logic        m_rep_wait;
  expect_t     exp_now;
  integer      seed;
  int          err_count = 0;
  int          check_count = 0;
  int          test_err_base = 0;
  int          rep_high_count = 0;
  int          cycles = 0;

  execute i_dut (
    .clk(clk), .rst(rst), .ex_v(ex_v), .ex_uop(ex_uop), .ex_a(ex_a), .ex_b(ex_b),
    .ex_c(ex_c), .ex_dr1(ex_dr1), .ex_dr2(ex_dr2), .wb_stall(wb_stall),
    .wb_v_next(wb_v_next), .wb_result_a_next(wb_result_a_next),
    .wb_result_b_next(wb_result_b_next), .wb_flags_next(wb_flags_next),
    .wb_ld_gpr1_next(wb_ld_gpr1_next), .wb_ld_gpr2_next(wb_ld_gpr2_next),
    .wb_dcache_write_next(wb_dcache_write_next), .wb_dr1_next(wb_dr1_next),
    .wb_dr2_next(wb_dr2_next), .dep_v_ld_gpr1(dep_v_ld_gpr1),
    .dep_v_ld_gpr2(dep_v_ld_gpr2), .dep_v_dcache_write(dep_v_dcache_write),
    .rep_again(rep_again)
  );

  always #10 clk = ~clk;

  function automatic expect_t exec_ref(input uop_t u, input logic v, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] c,
                                       input logic [31:0] held, input logic [31:0] count);
    expect_t     e;
    logic [31:0] bo;
    logic [31:0] mask;
    logic [31:0] msb;
    logic [31:0] raw;
    logic [31:0] tmp;
    logic [32:0] wide;
    logic [4:0]  nib;
    logic        sub;
    e = '0;
    // cmps second uop sees the captured operand as b
    bo  = u.is_cmps_second ? held : b;
    sub = (u.aluk == aluk_sub) || (u.aluk == aluk_cmp);
    case (u.size)
      size_byte: begin
        mask = 32'h0000_00ff;
        msb  = 32'h0000_0080;
      end
      size_word: begin
        mask = 32'h0000_ffff;
        msb  = 32'h0000_8000;
      end
      default: begin
        mask = 32'hffff_ffff;
        msb  = 32'h8000_0000;
      end
    endcase
    case (u.aluk)
      aluk_add:           raw = a + bo;
      aluk_sub, aluk_cmp: raw = a - bo;
      aluk_and:           raw = a & bo;
      aluk_or:            raw = a | bo;
      aluk_xor:           raw = a ^ bo;
      aluk_not:           raw = ~a;
      default:            raw = bo;
    endcase
    if (u.fu == fu_alu) begin
      e.result_a      = (a & ~mask) | (raw & mask);
      e.flags.bits.zf = ((raw & mask) == 32'd0);
      e.flags.bits.sf = |(raw & msb);
      e.flags.bits.pf = ~^raw[7:0];
      if (sub) begin
        e.flags.bits.cf = (a & mask) < (bo & mask);
        e.flags.bits.af = a[3:0] < bo[3:0];
        e.flags.bits.of = |((a ^ bo) & (a ^ raw) & msb);
      end else if (u.aluk == aluk_add) begin
        wide = {1'b0, a & mask} + {1'b0, bo & mask};
        nib  = {1'b0, a[3:0]} + {1'b0, bo[3:0]};
        e.flags.bits.cf = |(wide & {msb, 1'b0});
        e.flags.bits.af = nib[4];
        e.flags.bits.of = |(~(a ^ bo) & (a ^ raw) & msb);
      end
    end else begin
      e.result_a = a;
      if (bo[4:0] != 5'd0) begin
        // cf is the last bit that leaves the word
        if (u.shift_dir) begin
          e.result_a      = a >> bo[4:0];
          tmp             = a >> (bo[4:0] - 5'd1);
          e.flags.bits.cf = tmp[0];
        end else begin
          e.result_a      = a << bo[4:0];
          tmp             = a << (bo[4:0] - 5'd1);
          e.flags.bits.cf = tmp[31];
        end
        e.flags.bits.zf = (e.result_a == 32'd0);
        e.flags.bits.sf = e.result_a[31];
        e.flags.bits.pf = ~^e.result_a[7:0];
      end
    end
    e.result_b     = b;
    e.ld_gpr1      = u.ld_gpr1;
    e.ld_gpr2      = u.ld_gpr2;
    e.dcache_write = u.dcache_write;
    if (u.pass_a) begin
      e.result_a = a;
    end
    if (u.is_xchg) begin
      e.result_a = b;
      e.result_b = a;
    end
    if (u.is_cmpxchg && e.flags.bits.zf) begin
      e.result_a = c;
      e.ld_gpr2  = 1'b0;
    end else if (u.is_cmpxchg) begin
      e.result_a     = b;
      e.ld_gpr1      = 1'b1;
      e.dcache_write = 1'b0;
    end
    if (u.aluk == aluk_cmp) begin
      e.ld_gpr1 = 1'b0;
    end
    e.rep_again = v & u.is_cmps_second & u.is_rep & e.flags.bits.zf & (count != 32'd1);
    return e;
  endfunction

  task automatic check_word(input string what, input logic [`EX_DATA_W-1:0] got,
                            input logic [`EX_DATA_W-1:0] want);
    check_count++;
    if (got !== want) begin
      err_count++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flags(input string what, input eflags_u got, input eflags_u want);
    check_count++;
    if (got.word !== want.word) begin
      err_count++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got.word, want.word);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic want);
    check_count++;
    if (got !== want) begin
      err_count++;
      $display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // outputs settle mid cycle, state moves at the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      m_held     = '0;
      m_count    = '0;
      m_rep_wait = 1'b0;
    end else begin
      exp_now = exec_ref(ex_uop, ex_v, ex_a, ex_b, ex_c, m_held, m_count);
      check_word("result_a", wb_result_a_next, exp_now.result_a);
      check_word("result_b", wb_result_b_next, exp_now.result_b);
      check_word("dr", {26'd0, wb_dr2_next, wb_dr1_next}, {26'd0, ex_dr2, ex_dr1});
      check_flags("flags", wb_flags_next, exp_now.flags);
      check_bit("wb_v", wb_v_next, ex_v);
      check_bit("ld_gpr1", wb_ld_gpr1_next, exp_now.ld_gpr1);
      check_bit("ld_gpr2", wb_ld_gpr2_next, exp_now.ld_gpr2);
      check_bit("dcache_write", wb_dcache_write_next, exp_now.dcache_write);
      check_bit("dep_v_ld_gpr1", dep_v_ld_gpr1, exp_now.ld_gpr1 & ex_v);
      check_bit("dep_v_ld_gpr2", dep_v_ld_gpr2, exp_now.ld_gpr2 & ex_v);
      check_bit("dep_v_dcache_write", dep_v_dcache_write, exp_now.dcache_write & ex_v);
      check_bit("rep_again", rep_again, exp_now.rep_again);
      if (rep_again) begin
        rep_high_count++;
      end
      if (ex_v && !wb_stall && ex_uop.is_cmps_first) begin
        m_held = ex_a;
        if (ex_uop.is_rep && !m_rep_wait) begin
          m_count = ex_c;
        end
        m_rep_wait = 1'b0;
      end else if (ex_v && !wb_stall && ex_uop.is_cmps_second) begin
        if (ex_uop.is_rep) begin
          m_count = m_count - 32'd1;
        end
        m_rep_wait = exp_now.rep_again;
      end
    end
  end

  task automatic drive_op(input uop_t u, input logic v, input logic stall,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    logic [31:0] r;
    @(posedge clk);
    #1;
    r        = $random(seed);
    ex_uop   = u;
    ex_v     = v;
    wb_stall = stall;
    ex_a     = a;
    ex_b     = b;
    ex_c     = c;
    ex_dr1   = r[2:0];
    ex_dr2   = r[5:3];
  endtask

  task automatic finish_test(input string name);
    drive_op('0, 1'b0, 1'b0, 32'd0, 32'd0, 32'd0);
    $display("test %s done with %0d errors", name, err_count - test_err_base);
    test_err_base = err_count;
  endtask

  task automatic run_alu_ops();
    uop_t        u;
    logic [31:0] r;
    logic [31:0] a;
    for (int i = 0; i < n_alu; i++) begin
      r         = $random(seed);
      a         = $random(seed);
      u         = '0;
      u.aluk    = aluk_e'(r[2:0]);
      u.size    = (r[4:3] == 2'd3) ? size_dword : size_e'(r[4:3]);
      u.ld_gpr1 = 1'b1;
      // equal and complemented operands hit the zero and carry edges
      case (r[6:5])
        2'd0:    drive_op(u, 1'b1, r[7] & r[8], a, a, $random(seed));
        2'd1:    drive_op(u, 1'b1, r[7] & r[8], a, ~a, $random(seed));
        default: drive_op(u, 1'b1, r[7] & r[8], a, $random(seed), $random(seed));
      endcase
    end
    finish_test("alu");
  endtask

  task automatic run_shift_ops();
    uop_t        u;
    logic [31:0] r;
    logic [31:0] b;
    for (int i = 0; i < n_shift; i++) begin
      r           = $random(seed);
      u           = '0;
      u.fu        = fu_shift;
      u.shift_dir = r[0];
      u.ld_gpr1   = 1'b1;
      b           = (r[3:1] == 3'd0) ? 32'd0 : $random(seed);
      drive_op(u, 1'b1, 1'b0, $random(seed), b, 32'd0);
    end
    finish_test("shift");
  endtask

  task automatic run_xchg_ops();
    uop_t        u;
    logic [31:0] r;
    logic [31:0] a;
    for (int i = 0; i < 4; i++) begin
      u         = '0;
      u.aluk    = aluk_pass_b;
      u.is_xchg = 1'b1;
      u.ld_gpr1 = 1'b1;
      u.ld_gpr2 = 1'b1;
      drive_op(u, 1'b1, 1'b0, $random(seed), $random(seed), 32'd0);
    end
    for (int i = 0; i < n_cmpx; i++) begin
      r              = $random(seed);
      a              = $random(seed);
      u              = '0;
      u.aluk         = aluk_sub;
      u.size         = size_dword;
      u.is_cmpxchg   = 1'b1;
      // destination in a register or in memory
      u.ld_gpr2      = ~r[0];
      u.dcache_write = r[0];
      drive_op(u, r[1] | r[2], 1'b0, a, r[3] ? a : $random(seed), $random(seed));
    end
    finish_test("xchg");
  endtask

  task automatic run_cmps_pairs();
    uop_t        first;
    uop_t        second;
    logic [31:0] r;
    logic [31:0] held_val;
    for (int i = 0; i < n_cmps; i++) begin
      r                     = $random(seed);
      held_val              = $random(seed);
      first                 = '0;
      first.aluk            = aluk_pass_b;
      first.size            = size_dword;
      first.is_cmps_first   = 1'b1;
      second                = '0;
      second.aluk           = aluk_cmp;
      second.size           = size_dword;
      second.is_cmps_second = 1'b1;
      drive_op(first, 1'b1, 1'b0, held_val, $random(seed), 32'd0);
      // stalled first uop carries another value that must not be captured
      drive_op(first, 1'b1, 1'b1, ~held_val, $random(seed), 32'd0);
      drive_op(second, 1'b1, 1'b1, held_val, $random(seed), 32'd0);
      drive_op(second, 1'b1, 1'b0, r[0] ? held_val : $random(seed), $random(seed), 32'd0);
    end
    finish_test("cmps");
  endtask

  task automatic repe_pair(input logic [31:0] ecx, input logic [31:0] a_first,
                           input logic [31:0] a_second);
    uop_t u;
    u               = '0;
    u.aluk          = aluk_pass_b;
    u.size          = size_dword;
    u.is_rep        = 1'b1;
    u.is_cmps_first = 1'b1;
    drive_op(u, 1'b1, 1'b0, a_first, 32'd0, ecx);
    u.aluk           = aluk_cmp;
    u.is_cmps_first  = 1'b0;
    u.is_cmps_second = 1'b1;
    drive_op(u, 1'b1, 1'b0, a_second, $random(seed), ecx);
  endtask

  task automatic run_repe_cmps();
    logic [31:0] d;
    d = $random(seed);
    // ecx of 3 with equal data repeats twice
    repe_pair(32'd3, d, d);
    repe_pair(32'd9, d + 32'd1, d + 32'd1);
    repe_pair(32'd9, d + 32'd2, d + 32'd2);
    // mismatch on the second pass ends early
    repe_pair(32'd5, d, d);
    repe_pair(32'd5, d, d ^ 32'h10);
    drive_op('0, 1'b0, 1'b0, 32'd0, 32'd0, 32'd0);
    if (rep_high_count != 3) begin
      err_count++;
      $display("Mismatch at time %0t: rep_again high in %0d cycles, expected 3",
               $time, rep_high_count);
    end
    finish_test("repe");
  endtask

  initial begin
    seed     = 27;
    clk      = 1'b0;
    rst      = 1'b1;
    ex_v     = 1'b0;
    ex_uop   = '0;
    ex_a     = '0;
    ex_b     = '0;
    ex_c     = '0;
    ex_dr1   = '0;
    ex_dr2   = '0;
    wb_stall = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    run_alu_ops();
    run_shift_ops();
    run_xchg_ops();
    run_cmps_pairs();
    run_repe_cmps();
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

/* vlog.f */
+incdir+logic
logic/ex_uop_pkg.sv
logic/ex_flags_pkg.sv
logic/ex_ifs.sv
logic/cmps_seq_ex.sv
logic/rep_count_ex.sv
logic/alu32.sv
logic/shifter32.sv
logic/result_select_ex.sv
logic/execute.sv
sim/execute_checker.sv
sim/execute_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with verilator
rm -f sim.log
verilator --binary --timing --assert --top-module execute_tb -f vlog.f > build.log 2>&1 \
  && ./obj_dir/Vexecute_tb +verilator+error+limit+100 > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
  && echo "simulation passed" \
  || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
